/* src/spi_slave_pkg.sv */
package spi_slave_pkg;

  // ------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------

  // receive fifo entries
  localparam int RX_DEPTH    = 4;
  // flops on each spi pin before edge detection
  localparam int SYNC_STAGES = 2;
  // axi4-lite byte address width
  localparam int AXI_ADDR_W  = 4;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------

  // register map, word aligned
  typedef enum logic [3:0] {
    REG_CTRL   = 4'h0,
    REG_STATUS = 4'h4,
    REG_TXDATA = 4'h8,
    REG_RXDATA = 4'hC
  } reg_addr_e;

  // byte framing fsm
  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_shift
  } ctrl_state_e;

  // ------------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------------

  // spi mode bits as held in ctrl
  typedef struct packed {
    logic cpol;
    logic cpha;
  } spi_mode_t;

  // one-cycle strobes from the pin synchronizer
  typedef struct packed {
    logic cs_fall;
    logic cs_rise;
    logic sample;
    logic shift;
    logic mosi_s;
  } spi_strobe_t;

  // status register image, msb member first
  typedef struct packed {
    logic       tx_pending;
    logic       frame_err;
    logic       overflow;
    logic [2:0] rx_level;
  } status_t;

endpackage

/* src/spi_sck_sync.sv */
`timescale 1ns/1ps

module spi_sck_sync (
  input  logic                       sclk,
  input  logic                       rst_n,
  input  logic                       sck,
  input  logic                       cs_n,
  input  logic                       mosi,
  input  spi_slave_pkg::spi_mode_t   mode,
  output spi_slave_pkg::spi_strobe_t strb
);

  import spi_slave_pkg::*;

  // synchronizer chains with bit 0 as the first flop
  logic [SYNC_STAGES-1:0] sck_q;
  logic [SYNC_STAGES-1:0] cs_q;
  logic [SYNC_STAGES-1:0] mosi_q;

  // previous synced values for edge detect
  logic sck_d;
  logic cs_d;

  logic        sck_s;
  logic        cs_s;
  logic        rise;
  logic        fall;
  logic        lead;
  logic        trail;
  spi_strobe_t strb_d;

  assign sck_s = sck_q[SYNC_STAGES-1];
  assign cs_s  = cs_q[SYNC_STAGES-1];

  // ------------------------------------------------------------------
  // edge mapping
  // ------------------------------------------------------------------
  always_comb begin
    rise  = sck_s & ~sck_d;
    fall  = ~sck_s & sck_d;
    // leading edge leaves the idle level
    lead  = mode.cpol ? fall : rise;
    trail = mode.cpol ? rise : fall;
    strb_d.cs_fall = ~cs_s & cs_d;
    strb_d.cs_rise = cs_s & ~cs_d;
    // sck edges only count inside a frame
    strb_d.sample  = ~cs_s & (mode.cpha ? trail : lead);
    strb_d.shift   = ~cs_s & (mode.cpha ? lead : trail);
    strb_d.mosi_s  = mosi_q[SYNC_STAGES-1];
  end

  // two sync flops plus the strobe register give 3 cycles pin to strobe
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      sck_q  <= '0;
      cs_q   <= '1;
      mosi_q <= '0;
      sck_d  <= 1'b0;
      cs_d   <= 1'b1;
      strb   <= '0;
    end else begin
      sck_q  <= {sck_q[SYNC_STAGES-2:0], sck};
      cs_q   <= {cs_q[SYNC_STAGES-2:0], cs_n};
      mosi_q <= {mosi_q[SYNC_STAGES-2:0], mosi};
      sck_d  <= sck_s;
      cs_d   <= cs_s;
      strb   <= strb_d;
    end
  end

  // sck runs at most 1/8 of sclk so role strobes stay 4 cycles apart
  a_no_dual_strobe: assert property (
    @(posedge sclk) disable iff (!rst_n)
    (strb.sample || strb.shift) |->
      !$past(strb.sample || strb.shift, 1) &&
      !$past(strb.sample || strb.shift, 2) &&
      !$past(strb.sample || strb.shift, 3));

endmodule

/* src/spi_shift_reg.sv */
`timescale 1ns/1ps

module spi_shift_reg (
  input  logic       sclk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [7:0] tx_byte,
  input  logic       sample_en,
  input  logic       shift_en,
  input  logic       mosi_s,
  output logic [7:0] rx_byte,
  output logic       miso,
  input  logic       cs_active
);

  // separate chains so rx and tx bytes never mix
  logic [7:0] rx_sr;
  logic [7:0] tx_sr;

  // ------------------------------------------------------------------
  // receive chain
  // ------------------------------------------------------------------

  // msb first, newest bit enters at bit 0
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sr <= '0;
    end else if (sample_en) begin
      rx_sr <= {rx_sr[6:0], mosi_s};
    end
  end

  // full byte valid the cycle after the 8th sample
  assign rx_byte = rx_sr;

  // ------------------------------------------------------------------
  // transmit chain
  // ------------------------------------------------------------------

  // load wins over shift, it marks a byte boundary
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      tx_sr <= '1;
    end else if (load) begin
      tx_sr <= tx_byte;
    end else if (shift_en) begin
      tx_sr <= {tx_sr[6:0], 1'b1};
    end
  end

  // bit 7 is always the bit on the wire
  // idle high outside a frame
  assign miso = cs_active ? tx_sr[7] : 1'b1;

endmodule

/* src/spi_rx_fifo.sv */
`timescale 1ns/1ps

module spi_rx_fifo (
  input  logic       sclk,
  input  logic       rst_n,
  input  logic       push,
  input  logic [7:0] din,
  input  logic       pop,
  output logic [7:0] dout,
  output logic [2:0] level,
  output logic       full,
  output logic       empty
);

  import spi_slave_pkg::*;

  // storage and pointers, depth is a power of two so pointers wrap
  logic [7:0]                    mem [RX_DEPTH];
  logic [$clog2(RX_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(RX_DEPTH)-1:0]   rd_ptr;
  logic                          do_push;
  logic                          do_pop;

  assign full    = (level == 3'(RX_DEPTH));
  assign empty   = (level == 3'd0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // head entry, read path has no latency
  assign dout = mem[rd_ptr];

  // ------------------------------------------------------------------
  // pointers and level
  // ------------------------------------------------------------------
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the level
      case ({do_push, do_pop})
        2'b10:   level <= level + 3'd1;
        2'b01:   level <= level - 3'd1;
        default: level <= level;
      endcase
    end
  end

  // ctrl drops bytes itself when full, regs only pop when not empty
  a_no_push_full: assert property (
    @(posedge sclk) disable iff (!rst_n) push |-> !full);
  a_no_pop_empty: assert property (
    @(posedge sclk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* src/spi_slave_ctrl.sv */
`timescale 1ns/1ps

module spi_slave_ctrl (
  input  logic                       sclk,
  input  logic                       rst_n,
  input  spi_slave_pkg::spi_strobe_t strb,
  input  logic                       fifo_full,
  input  logic                       status_clr,
  output logic                       load,
  output logic                       sample_en,
  output logic                       shift_en,
  output logic                       push,
  output logic                       overflow,
  output logic                       frame_err,
  output logic                       byte_start
);

  import spi_slave_pkg::*;

  ctrl_state_e state;
  logic [2:0]  bit_cnt;
  logic        last_bit;

  // ------------------------------------------------------------------
  // strobe gating
  // ------------------------------------------------------------------

  // st_load waits at a byte boundary, next shift edge reloads
  // instead of shifting out a stale bit
  assign load       = strb.cs_fall || (state == st_load && strb.shift);
  assign shift_en   = (state == st_shift) && strb.shift;
  assign sample_en  = (state != st_idle) && strb.sample;
  assign byte_start = load;
  assign last_bit   = sample_en && (bit_cnt == 3'd7);

  // ------------------------------------------------------------------
  // fsm, bit count, flags
  // ------------------------------------------------------------------
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      bit_cnt   <= '0;
      push      <= 1'b0;
      overflow  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      // push lands one cycle after the 8th sample
      push <= last_bit && !fifo_full;
      // clear first so a new event in the same cycle is kept
      if (status_clr) begin
        overflow  <= 1'b0;
        frame_err <= 1'b0;
      end
      if (last_bit && fifo_full) begin
        overflow <= 1'b1;
      end
      if (strb.cs_rise) begin
        // partial byte at frame end, nothing is pushed
        if (bit_cnt != 3'd0) begin
          frame_err <= 1'b1;
        end
        state   <= st_idle;
        bit_cnt <= '0;
      end else if (strb.cs_fall) begin
        state   <= st_load;
        bit_cnt <= '0;
      end else if (sample_en) begin
        bit_cnt <= bit_cnt + 3'd1;
        // 8th bit ends the byte, back to boundary state
        state   <= last_bit ? st_load : st_shift;
      end
    end
  end

  // sync masks sck while cs_n high, so idle never sees a sample
  a_no_sample_idle: assert property (
    @(posedge sclk) disable iff (!rst_n) state == st_idle |-> !strb.sample);

endmodule

/* src/spi_axil_regs.sv */
`timescale 1ns/1ps

module spi_axil_regs (
  input  logic                                 sclk,
  input  logic                                 rst_n,
  input  logic [spi_slave_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [31:0]                          wdata,
  input  logic [3:0]                           wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [spi_slave_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [31:0]                          rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,
  output spi_slave_pkg::spi_mode_t             mode,
  output logic [7:0]                           tx_byte,
  input  logic                                 byte_start,
  input  logic [7:0]                           fifo_dout,
  input  logic [2:0]                           fifo_level,
  input  logic                                 fifo_empty,
  output logic                                 pop,
  input  logic                                 overflow,
  input  logic                                 frame_err,
  output logic                                 status_clr
);

  import spi_slave_pkg::*;

  logic    wr_rdy;
  logic    rd_rdy;
  logic    wr_go;
  logic    rd_go;
  logic    tx_pending;
  status_t sts;

  // aw and w accepted together with one transaction in flight per side
  assign wr_go   = awvalid && wvalid && !wr_rdy && !bvalid;
  assign rd_go   = arvalid && !rd_rdy && !rvalid;
  assign awready = wr_rdy;
  assign wready  = wr_rdy;
  assign arready = rd_rdy;

  assign sts = '{tx_pending: tx_pending, frame_err: frame_err,
                 overflow: overflow, rx_level: fifo_level};

  // head byte leaves the fifo in the ar handshake cycle
  assign pop = rd_rdy && (araddr == REG_RXDATA) && !fifo_empty;

  // ------------------------------------------------------------------
  // write channel
  // ------------------------------------------------------------------
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_rdy     <= 1'b0;
      bvalid     <= 1'b0;
      bresp      <= RESP_OKAY;
      mode       <= '0;
      tx_byte    <= '0;
      tx_pending <= 1'b0;
    end else begin
      wr_rdy <= wr_go;
      // tx byte consumed by the shifter
      if (byte_start) begin
        tx_pending <= 1'b0;
      end
      if (wr_rdy) begin
        bvalid <= 1'b1;
        bresp  <= RESP_OKAY;
        case (awaddr)
          REG_CTRL: begin
            // ctrl bit 0 is cpol and bit 1 is cpha
            if (wstrb[0]) begin
              mode.cpol <= wdata[0];
              mode.cpha <= wdata[1];
            end
          end
          REG_TXDATA: begin
            if (wstrb[0]) begin
              tx_byte    <= wdata[7:0];
              tx_pending <= 1'b1;
            end
          end
          // status and rxdata are read only
          default: bresp <= RESP_SLVERR;
        endcase
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // read channel
  // ------------------------------------------------------------------
  always_ff @(posedge sclk or negedge rst_n) begin
    if (!rst_n) begin
      rd_rdy     <= 1'b0;
      rvalid     <= 1'b0;
      rresp      <= RESP_OKAY;
      rdata      <= '0;
      status_clr <= 1'b0;
    end else begin
      rd_rdy <= rd_go;
      // flags clear once their value is on rdata
      status_clr <= rd_rdy && (araddr == REG_STATUS);
      if (rd_rdy) begin
        rvalid <= 1'b1;
        rresp  <= RESP_OKAY;
        rdata  <= '0;
        case (araddr)
          REG_CTRL:   rdata <= {30'd0, mode.cpha, mode.cpol};
          REG_STATUS: rdata <= {26'd0, sts};
          REG_TXDATA: rdata <= {24'd0, tx_byte};
          REG_RXDATA: begin
            if (fifo_empty) begin
              rresp <= RESP_SLVERR;
            end else begin
              rdata <= {24'd0, fifo_dout};
            end
          end
          default: rresp <= RESP_SLVERR;
        endcase
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // response and its code held until the master takes it
  a_bvalid_hold: assert property (
    @(posedge sclk) disable iff (!rst_n) bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

/* src/spi_slave_top.sv */
`timescale 1ns/1ps

module spi_slave_top (
  input  logic                                 sclk,
  input  logic                                 rst_n,
  input  logic                                 sck,
  input  logic                                 cs_n,
  input  logic                                 mosi,
  output logic                                 miso,
  input  logic [spi_slave_pkg::AXI_ADDR_W-1:0] awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [31:0]                          wdata,
  input  logic [3:0]                           wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [spi_slave_pkg::AXI_ADDR_W-1:0] araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [31:0]                          rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready
);

  import spi_slave_pkg::*;

  // ------------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------------
  spi_strobe_t strb;
  spi_mode_t   mode;
  logic [7:0]  tx_byte;
  logic [7:0]  rx_byte;
  logic [7:0]  fifo_dout;
  logic [2:0]  fifo_level;
  logic        fifo_full;
  logic        fifo_empty;
  logic        load;
  logic        sample_en;
  logic        shift_en;
  logic        push;
  logic        pop;
  logic        overflow;
  logic        frame_err;
  logic        status_clr;
  logic        byte_start;
  logic        cs_active;

  // miso follows the raw pin, no sync delay on release
  assign cs_active = ~cs_n;

  // pins to strobes
  spi_sck_sync u_spi_sck_sync (
    .sclk  (sclk),
    .rst_n (rst_n),
    .sck   (sck),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .mode  (mode),
    .strb  (strb)
  );

  // byte framing and error flags
  spi_slave_ctrl u_spi_slave_ctrl (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .strb       (strb),
    .fifo_full  (fifo_full),
    .status_clr (status_clr),
    .load       (load),
    .sample_en  (sample_en),
    .shift_en   (shift_en),
    .push       (push),
    .overflow   (overflow),
    .frame_err  (frame_err),
    .byte_start (byte_start)
  );

  spi_shift_reg u_spi_shift_reg (
    .sclk      (sclk),
    .rst_n     (rst_n),
    .load      (load),
    .tx_byte   (tx_byte),
    .sample_en (sample_en),
    .shift_en  (shift_en),
    .mosi_s    (strb.mosi_s),
    .rx_byte   (rx_byte),
    .miso      (miso),
    .cs_active (cs_active)
  );

  spi_rx_fifo u_spi_rx_fifo (
    .sclk  (sclk),
    .rst_n (rst_n),
    .push  (push),
    .din   (rx_byte),
    .pop   (pop),
    .dout  (fifo_dout),
    .level (fifo_level),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  // host side register file
  spi_axil_regs u_spi_axil_regs (
    .sclk       (sclk),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .mode       (mode),
    .tx_byte    (tx_byte),
    .byte_start (byte_start),
    .fifo_dout  (fifo_dout),
    .fifo_level (fifo_level),
    .fifo_empty (fifo_empty),
    .pop        (pop),
    .overflow   (overflow),
    .frame_err  (frame_err),
    .status_clr (status_clr)
  );

endmodule

/* sim/tb_spi_slave_top.sv */
`timescale 1ns/1ps

module tb_spi_slave_top;

  import spi_slave_pkg::*;

  // sck half period in sclk cycles for sck at 1/16 of sclk
  localparam int HALF_SCK = 8;
  // cycles allowed for any handshake
  localparam int TIMEOUT  = 200;

  // one stimulus row
  typedef struct packed {
    spi_mode_t       mode;
    int              nbits;
    logic [7:0]      tx;
    logic [4:0][7:0] mosi;
    int              exp_cnt;
    logic [3:0][7:0] exp_rx;
    logic [1:0]      exp_resp;
    logic [31:0]     exp_status;
  } vec_t;

  logic                  sclk;
  logic                  rst_n;
  logic                  sck;
  logic                  cs_n;
  logic                  mosi;
  logic                  miso;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [31:0]           wdata;
  logic [3:0]            wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;

  vec_t        tbl[$];
  integer      seed;
  int          errors;
  int          checks;
  logic [31:0] data;
  logic [1:0]  resp;

  spi_slave_top u_spi_slave_top (
    .sclk    (sclk),    .rst_n   (rst_n),
    .sck     (sck),     .cs_n    (cs_n),    .mosi    (mosi),    .miso    (miso),
    .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
    .wdata   (wdata),   .wstrb   (wstrb),   .wvalid  (wvalid),  .wready  (wready),
    .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
    .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
    .rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),  .rready  (rready)
  );

  always #5 sclk = ~sclk;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic give_up(input string what);
    errors++;
    $display("ERROR at %0t: timeout waiting for %s", $time, what);
    $display("checks: %0d  errors: %0d", checks, errors);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sclk);
    #1;
  endtask

  // status fields packed from tx_pending at the top down to rx_level
  function automatic logic [31:0] status_word(input logic [2:0] level, input logic ovf,
                                              input logic ferr, input logic txp);
    return {26'd0, txp, ferr, ovf, level};
  endfunction

  // byte 0 goes out first with its msb leading
  function automatic logic [5:0] stream_pos(input int k);
    int p;
    p = (k / 8) * 8 + 7 - (k % 8);
    return p[5:0];
  endfunction

  // ------------------------------------------------------------------
  // axi4-lite master
  // ------------------------------------------------------------------
  task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] wd,
                           output logic [1:0] br);
    int t;
    @(posedge sclk);
    #1;
    awaddr  = addr;
    wdata   = wd;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    t = 0;
    // aw and w are taken in the same cycle
    while (!(awready && wready) && t < TIMEOUT) begin
      @(negedge sclk);
      t++;
    end
    if (!(awready && wready)) give_up("awready and wready");
    @(posedge sclk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    t = 0;
    while (!bvalid && t < TIMEOUT) begin
      @(negedge sclk);
      t++;
    end
    if (!bvalid) give_up("bvalid");
    br = bresp;
    @(posedge sclk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] rd,
                          output logic [1:0] rr);
    int t;
    @(posedge sclk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    t = 0;
    while (!arready && t < TIMEOUT) begin
      @(negedge sclk);
      t++;
    end
    if (!arready) give_up("arready");
    @(posedge sclk);
    #1;
    arvalid = 1'b0;
    t = 0;
    while (!rvalid && t < TIMEOUT) begin
      @(negedge sclk);
      t++;
    end
    if (!rvalid) give_up("rvalid");
    rd = rdata;
    rr = rresp;
    @(posedge sclk);
    #1;
    rready = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // bit-banged spi master
  // ------------------------------------------------------------------
  task automatic spi_frame(input spi_mode_t m, input int nbits, input logic [39:0] out_bits,
                           output logic [39:0] in_bits);
    int k;
    in_bits = '0;
    sck = m.cpol;
    wait_cycles(HALF_SCK);
    cs_n = 1'b0;
    // cpha 0 puts the first bit out before any edge
    if (!m.cpha) mosi = out_bits[stream_pos(0)];
    wait_cycles(HALF_SCK);
    for (k = 0; k < nbits; k++) begin
      // leading edge
      sck = ~sck;
      if (m.cpha) mosi = out_bits[stream_pos(k)];
      else in_bits[stream_pos(k)] = miso;
      wait_cycles(HALF_SCK);
      // trailing edge
      sck = ~sck;
      if (m.cpha) in_bits[stream_pos(k)] = miso;
      else if (k + 1 < nbits) mosi = out_bits[stream_pos(k + 1)];
      wait_cycles(HALF_SCK);
    end
    cs_n = 1'b1;
    mosi = 1'b0;
    // let cs_rise and the last push settle
    wait_cycles(2 * HALF_SCK);
  endtask

  // ------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------
  task automatic add_vec(input logic [1:0] m, input int nbits, input logic [7:0] tx,
                         input logic [31:0] status);
    vec_t tv;
    int   r;
    int   i;
    tv.mode  = spi_mode_t'(m);
    tv.nbits = nbits;
    tv.tx    = tx;
    for (i = 0; i < 5; i++) begin
      r = $random(seed);
      tv.mosi[i[2:0]] = r[7:0];
    end
    // fifo keeps only the first four bytes of a frame
    tv.exp_cnt    = (nbits / 8 > RX_DEPTH) ? RX_DEPTH : nbits / 8;
    tv.exp_rx     = tv.mosi[3:0];
    // one extra read once drained hits an empty fifo
    tv.exp_resp   = RESP_SLVERR;
    tv.exp_status = status;
    tbl.push_back(tv);
  endtask

  task automatic run_vector(input int v, input vec_t tv);
    logic [31:0]     rd;
    logic [1:0]      rr;
    logic [4:0][7:0] got;
    int              i;
    // ctrl takes cpol in bit 0 and cpha in bit 1
    axi_write(REG_CTRL, {30'd0, tv.mode.cpha, tv.mode.cpol}, rr);
    check_val($sformatf("vec %0d ctrl bresp", v), {30'd0, rr}, {30'd0, RESP_OKAY});
    axi_write(REG_TXDATA, {24'd0, tv.tx}, rr);
    check_val($sformatf("vec %0d txdata bresp", v), {30'd0, rr}, {30'd0, RESP_OKAY});
    // tx byte waits for the frame
    axi_read(REG_STATUS, rd, rr);
    check_val($sformatf("vec %0d status before", v), rd, status_word(3'd0, 1'b0, 1'b0, 1'b1));
    spi_frame(tv.mode, tv.nbits, tv.mosi, got);
    // every full byte carries the tx byte back
    for (i = 0; i < tv.nbits / 8; i++) begin
      check_val($sformatf("vec %0d miso byte %0d", v, i), {24'd0, got[i[2:0]]}, {24'd0, tv.tx});
    end
    check_val($sformatf("vec %0d miso idle", v), {31'd0, miso}, 32'd1);
    axi_read(REG_STATUS, rd, rr);
    check_val($sformatf("vec %0d status after", v), rd, tv.exp_status);
    // sticky flags gone after one status read
    axi_read(REG_STATUS, rd, rr);
    check_val($sformatf("vec %0d status cleared", v), rd, tv.exp_status & ~32'h18);
    for (i = 0; i < tv.exp_cnt; i++) begin
      axi_read(REG_RXDATA, rd, rr);
      check_val($sformatf("vec %0d rxdata %0d", v, i), rd, {24'd0, tv.exp_rx[i[1:0]]});
      check_val($sformatf("vec %0d rresp %0d", v, i), {30'd0, rr}, {30'd0, RESP_OKAY});
    end
    axi_read(REG_RXDATA, rd, rr);
    check_val($sformatf("vec %0d empty rresp", v), {30'd0, rr}, {30'd0, tv.exp_resp});
    check_val($sformatf("vec %0d empty rdata", v), rd, 32'd0);
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    seed    = 32'heb5f;
    errors  = 0;
    checks  = 0;
    sclk    = 1'b0;
    rst_n   = 1'b0;
    sck     = 1'b0;
    cs_n    = 1'b1;
    mosi    = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (2) @(posedge sclk);
    #1;
    rst_n = 1'b1;

    // one byte in each of the four modes
    add_vec(2'd0, 8, 8'hA5, status_word(3'd1, 1'b0, 1'b0, 1'b0));
    add_vec(2'd1, 8, 8'h3C, status_word(3'd1, 1'b0, 1'b0, 1'b0));
    add_vec(2'd2, 8, 8'h96, status_word(3'd1, 1'b0, 1'b0, 1'b0));
    add_vec(2'd3, 8, 8'h71, status_word(3'd1, 1'b0, 1'b0, 1'b0));
    // three byte frame
    add_vec(2'd1, 24, 8'h5A, status_word(3'd3, 1'b0, 1'b0, 1'b0));
    // five bytes into a four entry fifo
    add_vec(2'd2, 40, 8'hC3, status_word(3'd4, 1'b1, 1'b0, 1'b0));
    // frame cut after 5 bits
    add_vec(2'd0, 5, 8'h81, status_word(3'd0, 1'b0, 1'b1, 1'b0));

    // reset values
    axi_read(REG_CTRL, data, resp);
    check_val("reset ctrl", data, 32'd0);
    axi_read(REG_STATUS, data, resp);
    check_val("reset status", data, 32'd0);
    check_val("reset miso", {31'd0, miso}, 32'd1);

    foreach (tbl[v]) begin
      run_vector(v, tbl[v]);
    end

    // bad accesses
    axi_read(REG_RXDATA, data, resp);
    check_val("empty rxdata rresp", {30'd0, resp}, {30'd0, RESP_SLVERR});
    axi_read(4'h2, data, resp);
    check_val("unmapped rresp", {30'd0, resp}, {30'd0, RESP_SLVERR});
    axi_write(4'h6, 32'h1, resp);
    check_val("unmapped bresp", {30'd0, resp}, {30'd0, RESP_SLVERR});
    axi_write(REG_STATUS, 32'h1, resp);
    check_val("status write bresp", {30'd0, resp}, {30'd0, RESP_SLVERR});

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* spi_slave_top.f */
src/spi_slave_pkg.sv
src/spi_sck_sync.sv
src/spi_shift_reg.sv
src/spi_rx_fifo.sv
src/spi_slave_ctrl.sv
src/spi_axil_regs.sv
src/spi_slave_top.sv
sim/tb_spi_slave_top.sv

/* Makefile */
TB := tb_spi_slave_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TB) \
		-f spi_slave_top.f -o $(TB)

run: build
	@out=$$(./obj_dir/$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -Wall --top-module spi_slave_top \
		-f spi_slave_top.f

clean:
	rm -rf obj_dir
